// ==== dv/adc_chip_model.sv ====
// behavioral serial ADC for the testbench; decodes the command on din and shifts back a stored value
`timescale 1ns/1ns

module adc_chip_model import adc_pkg::*; (
    input  logic sclk,
    input  logic cs_n,
    input  logic din,
    output logic dout,
    output logic command_error
);

    adc_sample_t  channel_value [num_channels];  // written by the testbench
    int           rise_count;    // sclk rises since cs_n fell
    logic [4:0]   command_bits;  // start, sgl, d2, d1, d0
    adc_channel_t channel;
    adc_sample_t  data_shift;

    initial
    begin
        dout          = 1'b0;
        command_error = 1'b0;
        rise_count    = 0;
        command_bits  = '0;
        channel       = '0;
        data_shift    = '0;
    end

    // cs_n falling opens a frame, rises while selected clock in the command
    always @(negedge cs_n or posedge sclk)
    begin
        if (!sclk)
        begin
            rise_count   = 0;
            command_bits = '0;
        end
        else if (!cs_n)
        begin
            rise_count = rise_count + 1;
            if (rise_count <= 5)
                command_bits = {command_bits[3:0], din};
            if (rise_count == 5)
            begin
                channel = command_bits[2:0];
                if (command_bits[4:3] != 2'b11)
                    command_error = 1'b1;  // sticky, start or sgl missing
            end
        end
    end

    // answer on falling edges, null bit first, then b9 down to b0
    always @(negedge sclk)
    begin
        if (!cs_n && rise_count == 5)
        begin
            dout       <= 1'b0;
            data_shift <= channel_value[channel];
        end
        else if (!cs_n && rise_count >= 6 && rise_count <= 15)
        begin
            dout       <= data_shift[9];
            data_shift <= {data_shift[8:0], 1'b0};
        end
    end

endmodule

// ==== dv/adc_scan_assertions.sv ====
// concurrent checks on the ADC pins and the result port, bound into the scan controller top level
`timescale 1ns/1ns

module adc_scan_assertions import adc_pkg::*; (
    input logic        clock,
    input logic        reset,
    input logic        sclk,
    input logic        cs_n,
    input adc_result_t result,
    input logic        result_valid,
    input logic        result_ready
);

    int failure_count = 0;  // read by the testbench at the end

    sclk_low_when_deselected: assert property (@(posedge clock) disable iff (reset) cs_n |-> !sclk)
    else
    begin
        $error("sclk high while cs_n is high");
        failure_count++;
    end

    result_held_under_stall: assert property (@(posedge clock) disable iff (reset)
        result_valid && !result_ready |=> result_valid && $stable(result))
    else
    begin
        $error("result changed or dropped while result_ready was low");
        failure_count++;
    end

    idle_after_reset: assert property (@(posedge clock) reset |=> cs_n && !result_valid)
    else
    begin
        $error("cs_n low or result_valid high right after reset");
        failure_count++;
    end

endmodule

bind adc_scan_top adc_scan_assertions adc_scan_assertions_i (
    .clock        (clock),
    .reset        (reset),
    .sclk         (sclk),
    .cs_n         (cs_n),
    .result       (result),
    .result_valid (result_valid),
    .result_ready (result_ready)
);

// ==== dv/adc_scan_tb.sv ====
// testbench for the ADC scan controller; runs directed tests against an ADC model and checks results
`timescale 1ns/1ns

module adc_scan_tb import adc_pkg::*; ();

    localparam int timeout_cycles = 2000;  // longest wait for one result

    logic          clock;
    logic          reset;
    channel_mask_t channel_mask;
    logic          sclk;
    logic          cs_n;
    logic          din;
    logic          dout;
    adc_result_t   result;
    logic          result_valid;
    logic          result_ready;
    logic          command_error;

    int            error_count;
    int            check_count;
    integer        seed;
    adc_channel_t  last_channel;  // channel the last checked result should carry

    adc_scan_top #(
        .clock_div (3)
    ) adc_scan_top_i (
        .clock        (clock),
        .reset        (reset),
        .channel_mask (channel_mask),
        .sclk         (sclk),
        .cs_n         (cs_n),
        .din          (din),
        .dout         (dout),
        .result       (result),
        .result_valid (result_valid),
        .result_ready (result_ready)
    );

    adc_chip_model adc_chip_model_i (
        .sclk          (sclk),
        .cs_n          (cs_n),
        .din           (din),
        .dout          (dout),
        .command_error (command_error)
    );

    always #2 clock = ~clock;

    task automatic report_mismatch(input string test_name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        error_count++;
        $display("Error %s: expected %0h, actual %0h", test_name, expected, actual);
    endtask

    // next enabled channel above from with wraparound
    function automatic adc_channel_t expected_channel(channel_mask_t mask, adc_channel_t from);
        int index;
        index = (int'(from) + 1) % num_channels;
        for (int tries = 0; tries < num_channels && !mask[index]; tries++)
            index = (index + 1) % num_channels;
        return adc_channel_t'(index);
    endfunction

    task automatic check_idle_pins(input string test_name);
        check_count++;
        if (cs_n !== 1'b1)
            report_mismatch({test_name, " cs_n"}, 1, cs_n);
        if (sclk !== 1'b0)
            report_mismatch({test_name, " sclk"}, 0, sclk);
        if (din !== 1'b0)
            report_mismatch({test_name, " din"}, 0, din);
        if (result_valid !== 1'b0)
            report_mismatch({test_name, " result_valid"}, 0, result_valid);
    endtask

    // waits for one transfer, then checks channel order and sample value
    task automatic take_result(input string test_name, input bit random_ready);
        adc_channel_t want;
        int           waited;
        want   = expected_channel(channel_mask, last_channel);
        waited = 0;
        @(negedge clock);
        result_ready = random_ready ? 1'($random(seed)) : 1'b1;
        while (!(result_valid && result_ready) && waited < timeout_cycles)
        begin
            @(negedge clock);
            result_ready = random_ready ? 1'($random(seed)) : 1'b1;
            waited++;
        end
        if (!(result_valid && result_ready))
        begin
            error_count++;
            $display("Timeout in %s: no result transfer within %0d cycles", test_name, waited);
        end
        else
        begin
            check_count++;
            if (result.channel !== want)
                report_mismatch({test_name, " channel"}, want, result.channel);
            if (result.sample !== adc_chip_model_i.channel_value[want])
                report_mismatch({test_name, " sample"}, adc_chip_model_i.channel_value[want],
                                result.sample);
        end
        last_channel = want;
        @(negedge clock);  // transfer done on the edge before
        result_ready = 1'b0;
    endtask

    task automatic reset_test();
        repeat (16)
        begin
            @(negedge clock);
            check_idle_pins("reset");
        end
        reset = 1'b0;
        repeat (200)
        begin
            @(negedge clock);
            check_idle_pins("empty_mask");
        end
    endtask

    task automatic single_channel_test();
        for (int n = 0; n < num_channels; n++)
            adc_chip_model_i.channel_value[n] = adc_sample_t'(85 + 123 * n);  // all distinct
        channel_mask = 8'b0000_1000;
        repeat (5)
            take_result("single_channel", 1'b0);
    endtask

    task automatic scan_order_test();
        channel_mask = 8'b1010_0101;
        repeat (8)
            take_result("scan_order", 1'b0);  // two laps with a wrap from 7 to 0
    endtask

    task automatic back_pressure_test();
        adc_result_t held;
        int          waited;
        channel_mask = 8'b0100_1010;
        waited       = 0;
        @(negedge clock);
        while (!result_valid && waited < timeout_cycles)
        begin
            @(negedge clock);
            waited++;
        end
        if (!result_valid)
        begin
            error_count++;
            $display("Timeout in back_pressure: result_valid never rose");
        end
        held = result;
        repeat (1500)  // about ten frame lengths
        begin
            @(negedge clock);
            check_count++;
            if (result !== held)
                report_mismatch("back_pressure result", held, result);
            if (result_valid !== 1'b1)
                report_mismatch("back_pressure result_valid", 1, result_valid);
            if (cs_n !== 1'b1)
                report_mismatch("back_pressure cs_n", 1, cs_n);
        end
        repeat (6)
            take_result("back_pressure", 1'b0);
    endtask

    task automatic random_mask_test();
        channel_mask_t mask;
        for (int trial = 0; trial < 6; trial++)
        begin
            mask = '0;
            while (mask == '0)
                mask = channel_mask_t'($random(seed));
            for (int n = 0; n < num_channels; n++)
                adc_chip_model_i.channel_value[n] = adc_sample_t'($random(seed));
            channel_mask = mask;  // no frame in flight here
            repeat (2 * $countones(mask))
                take_result("random_mask", 1'b1);
        end
    endtask

    initial
    begin
        clock        = 1'b0;
        reset        = 1'b1;
        channel_mask = '0;
        result_ready = 1'b0;
        error_count  = 0;
        check_count  = 0;
        seed         = 32'h531c;
        last_channel = adc_channel_t'(num_channels - 1);  // scan opens at the lowest channel

        reset_test();
        single_channel_test();
        scan_order_test();
        back_pressure_test();
        random_mask_test();

        if (command_error)
        begin
            error_count++;
            $display("ADC model saw a frame without start or single-ended bit");
        end
        error_count += adc_scan_top_i.adc_scan_assertions_i.failure_count;
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// ==== flist.f ====
hw/adc_pkg.sv
hw/serial_clock_gen.sv
hw/adc_frame_ctrl.sv
hw/channel_scanner.sv
hw/adc_scan_top.sv
dv/adc_chip_model.sv
dv/adc_scan_assertions.sv
dv/adc_scan_tb.sv

// ==== hw/adc_frame_ctrl.sv ====
// conversion frame FSM: takes one channel request, runs the serial ADC frame and returns the sample
`timescale 1ns/1ns

module adc_frame_ctrl import adc_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  adc_channel_t request_channel,
    input  logic         request_valid,
    output logic         request_ready,
    output logic         run,
    input  logic         rise,
    input  logic         fall,
    output logic         cs_n,
    output logic         din,
    input  logic         dout,
    output logic         done,
    output adc_sample_t  sample
);

    // rise edge counts, numbered from zero
    localparam logic [4:0] last_command_rise = 5'd4;  // rise 5 carries d0
    localparam logic [4:0] last_data_rise    = 5'd15; // rise 16 carries b0

    // steps inside the deselect phase
    localparam logic [4:0] wait_fall     = 5'd16;
    localparam logic [4:0] raise_cs      = 5'd17;
    localparam logic [4:0] first_half    = 5'd18;
    localparam logic [4:0] restart_run   = 5'd19;
    localparam logic [4:0] second_half   = 5'd20;

    frame_state_t state;
    logic [4:0]   bit_count;  // rises seen in this frame, then deselect step
    logic [3:0]   cmd_shift;  // sgl, d2, d1, d0 still to send

    assign request_ready = (state == idle);

    always_ff @(posedge clock)
    begin
        done <= 1'b0;
        if (reset)
        begin
            state     <= idle;
            cs_n      <= 1'b1;
            din       <= 1'b0;
            run       <= 1'b0;
            bit_count <= '0;
        end
        else
        begin
            case (state)
                idle:
                begin
                    if (request_valid)
                    begin
                        state     <= select;
                        cs_n      <= 1'b0;
                        din       <= 1'b1;  // start bit
                        run       <= 1'b1;
                        bit_count <= '0;
                    end
                end
                select:
                begin
                    if (rise)
                    begin
                        bit_count <= bit_count + 5'd1;
                        state     <= command;
                    end
                end
                command:
                begin
                    if (fall)
                        din <= cmd_shift[3];
                    if (rise)
                    begin
                        bit_count <= bit_count + 5'd1;
                        if (bit_count == last_command_rise)
                            state <= null_bit;
                    end
                end
                null_bit:
                begin
                    if (fall)
                        din <= 1'b0;  // din is don't care from here on
                    if (rise)
                    begin
                        bit_count <= bit_count + 5'd1;
                        state     <= data;
                    end
                end
                data:
                begin
                    if (rise)
                    begin
                        bit_count <= bit_count + 5'd1;
                        if (bit_count == last_data_rise)
                            state <= deselect;
                    end
                end
                deselect:
                begin
                    // cs_n rises on the same edge that takes sclk low, then two
                    // half periods are timed with run dropped before each rise
                    case (bit_count)
                        wait_fall:
                        begin
                            if (fall)
                                bit_count <= raise_cs;
                        end
                        raise_cs:
                        begin
                            cs_n      <= 1'b1;
                            bit_count <= first_half;
                        end
                        first_half, second_half:
                        begin
                            if (rise)
                            begin
                                run       <= 1'b0;  // sclk stays low
                                bit_count <= bit_count + 5'd1;
                            end
                        end
                        restart_run:
                        begin
                            run       <= 1'b1;
                            bit_count <= second_half;
                        end
                        default:
                        begin
                            done  <= 1'b1;
                            state <= idle;
                        end
                    endcase
                end
                default:
                begin
                    state <= idle;
                end
            endcase
        end
    end

    // command bits go out msb first after the start bit
    always_ff @(posedge clock)
    begin
        if (request_ready && request_valid)
            cmd_shift <= {1'b1, request_channel};  // single-ended always
        else if (state == command && fall)
            cmd_shift <= {cmd_shift[2:0], 1'b0};
    end

    // b9 arrives first
    always_ff @(posedge clock)
    begin
        if (state == data && rise)
            sample <= {sample[8:0], dout};
    end

endmodule

// ==== hw/adc_pkg.sv ====
// shared types for the ADC scan controller, imported by the RTL modules and the testbench
package adc_pkg;

    // the command format carries three channel bits
    localparam int num_channels = 8;

    typedef logic [9:0] adc_sample_t;                 // one conversion, msb first on the wire
    typedef logic [2:0] adc_channel_t;                // d2 d1 d0 of the command
    typedef logic [num_channels-1:0] channel_mask_t;  // bit n enables channel n

    // one finished conversion as delivered on the result port
    typedef struct packed {
        adc_channel_t channel;
        adc_sample_t  sample;
    } adc_result_t;

    // phases of one conversion frame
    typedef enum logic [2:0] {
        idle,       // cs_n high, waiting for a request
        select,     // cs_n low, start bit on din before rise 1
        command,    // single-ended and channel bits, rises 2 to 5
        null_bit,   // rise 6, device sends its null bit
        data,       // rises 7 to 16, b9 down to b0
        deselect    // cs_n back high, hold off one sclk period
    } frame_state_t;

endpackage

// ==== hw/adc_scan_top.sv ====
// top level of the ADC scan controller: ADC pins on one side, valid/ready result port on the other
`timescale 1ns/1ns

module adc_scan_top import adc_pkg::*; #(
    parameter int clock_div = 3  // sclk period is 2*(clock_div+1) clocks
) (
    input  logic          clock,
    input  logic          reset,
    input  channel_mask_t channel_mask,
    output logic          sclk,
    output logic          cs_n,
    output logic          din,
    input  logic          dout,
    output adc_result_t   result,
    output logic          result_valid,
    input  logic          result_ready
);

    logic         run;
    logic         rise;
    logic         fall;
    adc_channel_t request_channel;
    logic         request_valid;
    logic         request_ready;
    logic         done;
    adc_sample_t  sample;

    serial_clock_gen #(
        .clock_div (clock_div)
    ) serial_clock_gen_i (
        .clock (clock),
        .reset (reset),
        .run   (run),
        .sclk  (sclk),
        .rise  (rise),
        .fall  (fall)
    );

    adc_frame_ctrl adc_frame_ctrl_i (
        .clock           (clock),
        .reset           (reset),
        .request_channel (request_channel),
        .request_valid   (request_valid),
        .request_ready   (request_ready),
        .run             (run),
        .rise            (rise),
        .fall            (fall),
        .cs_n            (cs_n),
        .din             (din),
        .dout            (dout),
        .done            (done),
        .sample          (sample)
    );

    channel_scanner channel_scanner_i (
        .clock           (clock),
        .reset           (reset),
        .channel_mask    (channel_mask),
        .request_channel (request_channel),
        .request_valid   (request_valid),
        .request_ready   (request_ready),
        .done            (done),
        .sample          (sample),
        .result          (result),
        .result_valid    (result_valid),
        .result_ready    (result_ready)
    );

endmodule

// ==== hw/channel_scanner.sv ====
// channel scanner: walks the enabled channels in ascending order and holds each result for the output port
`timescale 1ns/1ns

module channel_scanner import adc_pkg::*; (
    input  logic          clock,
    input  logic          reset,
    input  channel_mask_t channel_mask,
    output adc_channel_t  request_channel,
    output logic          request_valid,
    input  logic          request_ready,
    input  logic          done,
    input  adc_sample_t   sample,
    output adc_result_t   result,
    output logic          result_valid,
    input  logic          result_ready
);

    logic         pending;      // request taken, frame still running
    adc_channel_t next_choice;

    // first enabled channel above the current one, wrapping around;
    // a lone enabled channel finds itself on the last step
    function automatic adc_channel_t next_channel(channel_mask_t mask, adc_channel_t from);
        adc_channel_t candidate;
        adc_channel_t found;
        logic         hit;
        found = from;
        hit   = 1'b0;
        for (int step = 1; step <= num_channels; step++)
        begin
            candidate = from + adc_channel_t'(step);
            if (!hit && mask[candidate])
            begin
                found = candidate;
                hit   = 1'b1;
            end
        end
        return found;
    endfunction

    assign next_choice = next_channel(channel_mask, request_channel);

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            request_valid   <= 1'b0;
            pending         <= 1'b0;
            result_valid    <= 1'b0;
            request_channel <= adc_channel_t'(num_channels - 1);  // so the scan opens at channel 0
        end
        else
        begin
            if (request_valid && request_ready)
            begin
                request_valid <= 1'b0;
                pending       <= 1'b1;
            end
            else if (!request_valid && !pending && !result_valid && channel_mask != '0)
            begin
                request_channel <= next_choice;  // mask read only here
                request_valid   <= 1'b1;
            end

            if (done)
            begin
                pending      <= 1'b0;
                result_valid <= 1'b1;
            end
            else if (result_valid && result_ready)
            begin
                result_valid <= 1'b0;  // slot free, next request follows
            end
        end
    end

    // the channel register still names the frame that just finished
    always_ff @(posedge clock)
    begin
        if (done)
            result <= '{channel: request_channel, sample: sample};
    end

endmodule

// ==== hw/serial_clock_gen.sv ====
// serial clock divider for the ADC frame controller; gives sclk plus early rise and fall strobes
`timescale 1ns/1ns

module serial_clock_gen #(
    parameter int clock_div = 3  // system clocks per sclk half period, minus one
) (
    input  logic clock,
    input  logic reset,
    input  logic run,
    output logic sclk,
    output logic rise,
    output logic fall
);

    localparam int count_width = $clog2(clock_div + 1);

    localparam logic [count_width-1:0] last_count = count_width'(clock_div);
    localparam logic [count_width-1:0] strobe_count = count_width'(clock_div - 1);

    logic [count_width-1:0] count;  // position inside the current half period
    logic                   edge_soon;

    // counter and sclk restart from a low phase every time run comes up
    always_ff @(posedge clock)
    begin
        if (reset || !run)
        begin
            count <= '0;
            sclk  <= 1'b0;
        end
        else if (count == last_count)
        begin
            count <= '0;
            sclk  <= ~sclk;  // half period done
        end
        else
        begin
            count <= count + 1'b1;
        end
    end

    // The strobes come one cycle ahead of the sclk edge. A user that drops run on a
    // rise strobe keeps sclk low, which the frame controller uses to time cs_n high.
    assign edge_soon = run && (count == strobe_count);
    assign rise      = edge_soon && !sclk;  // sclk goes high one cycle later
    assign fall      = edge_soon && sclk;   // sclk goes low one cycle later

endmodule

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module adc_scan_tb -f flist.f -o adc_scan_sim \
    || { echo "build failed"; exit 1; }
sim_output=$(./obj_dir/adc_scan_sim 2>&1)
echo "$sim_output"
echo "$sim_output" | grep -qx "Done: no errors" && echo "PASS" || { echo "FAIL"; exit 1; }
